//--- logic/stat_pkg.sv
// Statistics package with counter widths, record types and default parameters
package stat_pkg;

    // Counters per channel: tx bytes, tx packets, rx bytes, rx packets
    localparam int STATS_PER_CH = 4;

    localparam int DEFAULT_CNT = 4;
    localparam int DEFAULT_UPDATE_PERIOD = 64;
    localparam int DEFAULT_ID_BASE = 0;

    localparam int STAT_INC_W = 4;
    localparam int STAT_VAL_W = 16;
    localparam int STAT_ID_W = 8;
    localparam int STAT_IDX_W = $clog2(STATS_PER_CH);

    // Per-cycle increment of one counter
    typedef logic [STAT_INC_W-1:0] stat_inc_t;

    // Accumulated value, wraps modulo 2^16
    typedef logic [STAT_VAL_W-1:0] stat_val_t;

    // Global counter ID
    typedef logic [STAT_ID_W-1:0] stat_id_t;

    // Counter index inside one channel
    typedef logic [STAT_IDX_W-1:0] stat_idx_t;

    // Per-channel increments, index 0 to 3 in field order
    typedef struct packed {
        stat_inc_t tx_byte;
        stat_inc_t tx_pkt;
        stat_inc_t rx_byte;
        stat_inc_t rx_pkt;
    } ch_stat_t;

    // One statistics record on the shared stream
    typedef struct packed {
        stat_id_t  id;
        stat_val_t value;
    } stat_rec_t;

endpackage

//--- logic/stat_period_timer.sv
// Statistics period timer issuing a one-cycle update tick every period
`timescale 1ns/1ps

module stat_period_timer #(
    parameter int STAT_UPDATE_PERIOD = stat_pkg::DEFAULT_UPDATE_PERIOD
) (
    input  logic stat_clk,
    input  logic rst_n,
    output logic update_tick
);

    localparam int CNT_W = $clog2(STAT_UPDATE_PERIOD);

    logic [CNT_W-1:0] cycle_cnt;

    // Counter runs 0 .. period-1 and wraps
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (cycle_cnt == CNT_W'(STAT_UPDATE_PERIOD - 1)) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Registered one cycle early so the tick lands on period boundaries
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            update_tick <= 1'b0;
        end else begin
            update_tick <= (cycle_cnt == CNT_W'(STAT_UPDATE_PERIOD - 2));
        end
    end

endmodule

//--- logic/stat_collector.sv
// Per-channel statistics collector with interval accumulators and record requests
`timescale 1ns/1ps

module stat_collector #(
    parameter int CH_ID_BASE = stat_pkg::DEFAULT_ID_BASE
) (
    input  logic                stat_clk,
    input  logic                rst_n,
    input  logic                update_tick,
    input  stat_pkg::ch_stat_t  stat_in,
    input  logic                grant,
    output logic                req,
    output stat_pkg::stat_rec_t rec
);

    import stat_pkg::*;

    stat_inc_t               inc [STATS_PER_CH];
    stat_val_t               acc [STATS_PER_CH];
    stat_val_t               snap [STATS_PER_CH];
    logic [STATS_PER_CH-1:0] pending;
    stat_idx_t               sel_idx;

    // Counter index order follows the struct field order
    assign inc[0] = stat_in.tx_byte;
    assign inc[1] = stat_in.tx_pkt;
    assign inc[2] = stat_in.rx_byte;
    assign inc[3] = stat_in.rx_pkt;

    // Interval accumulators
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STATS_PER_CH; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < STATS_PER_CH; i++) begin
                if (update_tick) begin
                    // Tick-cycle increment opens the next interval
                    acc[i] <= stat_val_t'(inc[i]);
                end else begin
                    acc[i] <= acc[i] + stat_val_t'(inc[i]);
                end
            end
        end
    end

    // Snapshot of the closed interval
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STATS_PER_CH; i++) begin
                snap[i] <= '0;
            end
        end else if (update_tick) begin
            for (int i = 0; i < STATS_PER_CH; i++) begin
                snap[i] <= acc[i];
            end
        end
    end

    // Pending mask, one bit per snapshot record
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (update_tick) begin
            pending <= '1;
        end else if (grant) begin
            pending[sel_idx] <= 1'b0;
        end
    end

    // Lowest pending index goes first
    always_comb begin
        sel_idx = '0;
        for (int i = STATS_PER_CH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_idx = stat_idx_t'(i);
            end
        end
    end

    assign req = |pending;

    assign rec.id    = stat_id_t'(CH_ID_BASE) + stat_id_t'(sel_idx);
    assign rec.value = snap[sel_idx];

endmodule

//--- logic/stat_arb_mux.sv
// Round-robin arbiter merging channel records onto the statistics output strobe
`timescale 1ns/1ps

module stat_arb_mux #(
    parameter int CNT = stat_pkg::DEFAULT_CNT
) (
    input  logic                stat_clk,
    input  logic                rst_n,
    input  logic [CNT-1:0]      req,
    input  stat_pkg::stat_rec_t rec [CNT],
    output logic [CNT-1:0]      grant,
    output logic                m_stat_valid,
    output stat_pkg::stat_rec_t m_stat_rec
);

    localparam int PTR_W = (CNT > 1) ? $clog2(CNT) : 1;

    logic [PTR_W-1:0] last_ptr;
    logic [PTR_W-1:0] gnt_idx;
    logic             gnt_any;

    // Search starts at the channel after the last grant
    always_comb begin : arb_search
        int cand;

        gnt_any = 1'b0;
        gnt_idx = '0;
        for (int i = 1; i <= CNT; i++) begin
            cand = int'(last_ptr) + i;
            if (cand >= CNT) begin
                cand = cand - CNT;
            end
            if (!gnt_any && req[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = PTR_W'(cand);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (gnt_any) begin
            grant[gnt_idx] = 1'b1;
        end
    end

    // Pointer starts at the last channel so channel 0 wins first
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ptr <= PTR_W'(CNT - 1);
        end else if (gnt_any) begin
            last_ptr <= gnt_idx;
        end
    end

    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            m_stat_valid <= 1'b0;
        end else begin
            m_stat_valid <= gnt_any;
        end
    end

    // Output record payload
    always_ff @(posedge stat_clk) begin
        if (gnt_any) begin
            m_stat_rec <= rec[gnt_idx];
        end
    end

endmodule

//--- logic/eth_stat_quad.sv
// Quad Ethernet MAC statistics block with per-channel collectors on one shared stream
`timescale 1ns/1ps

module eth_stat_quad #(
    parameter int CNT = stat_pkg::DEFAULT_CNT,
    parameter int STAT_UPDATE_PERIOD = stat_pkg::DEFAULT_UPDATE_PERIOD,
    parameter int STAT_ID_BASE = stat_pkg::DEFAULT_ID_BASE
) (
    input  logic                stat_clk,
    input  logic                rst_n,
    input  stat_pkg::ch_stat_t  stat_in [CNT],
    output logic                m_stat_valid,
    output stat_pkg::stat_rec_t m_stat_rec
);

    import stat_pkg::*;

    logic           update_tick;
    logic [CNT-1:0] ch_req;
    logic [CNT-1:0] ch_grant;
    stat_rec_t      ch_rec [CNT];

    stat_period_timer #(
        .STAT_UPDATE_PERIOD(STAT_UPDATE_PERIOD)
    ) i_stat_period_timer (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .update_tick(update_tick)
    );

    // One collector per channel, IDs offset by channel
    for (genvar n = 0; n < CNT; n++) begin : g_ch

        stat_collector #(
            .CH_ID_BASE(STAT_ID_BASE + n * STATS_PER_CH)
        ) i_stat_collector (
            .stat_clk(stat_clk),
            .rst_n(rst_n),
            .update_tick(update_tick),
            .stat_in(stat_in[n]),
            .grant(ch_grant[n]),
            .req(ch_req[n]),
            .rec(ch_rec[n])
        );

    end

    stat_arb_mux #(
        .CNT(CNT)
    ) i_stat_arb_mux (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .req(ch_req),
        .rec(ch_rec),
        .grant(ch_grant),
        .m_stat_valid(m_stat_valid),
        .m_stat_rec(m_stat_rec)
    );

endmodule

//--- verif/eth_stat_quad_chk.sv
// Assertion checker for the statistics arbiter grants and output strobe
`timescale 1ns/1ps

module eth_stat_quad_chk #(
    parameter int CNT = stat_pkg::DEFAULT_CNT
) (
    input logic           stat_clk,
    input logic           rst_n,
    input logic [CNT-1:0] req,
    input logic [CNT-1:0] grant,
    input logic           m_stat_valid
);

    localparam int WAIT_W = $clog2(CNT + 1);

    logic [WAIT_W-1:0] wait_cnt [CNT];

    // Cycles each channel has been requesting without a grant
    always_ff @(posedge stat_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CNT; i++) begin
                wait_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CNT; i++) begin
                if (req[i] && !grant[i]) begin
                    wait_cnt[i] <= wait_cnt[i] + 1'b1;
                end else begin
                    wait_cnt[i] <= '0;
                end
            end
        end
    end

    a_grant_onehot: assert property (@(posedge stat_clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    a_grant_to_req: assert property (@(posedge stat_clk) disable iff (!rst_n)
        (grant & ~req) == '0)
        else $error("grant given to a channel without a request");

    // Round robin bounds the wait of any requester
    for (genvar n = 0; n < CNT; n++) begin : g_wait
        a_grant_wait: assert property (@(posedge stat_clk) disable iff (!rst_n)
            wait_cnt[n] < WAIT_W'(CNT))
            else $error("channel %0d waited too long for a grant", n);
    end

    a_valid_after_grant: assert property (@(posedge stat_clk) disable iff (!rst_n)
        |grant |=> m_stat_valid)
        else $error("output not valid one cycle after a grant");

    a_valid_only_after_grant: assert property (@(posedge stat_clk) disable iff (!rst_n)
        !(|grant) |=> !m_stat_valid)
        else $error("output valid without a grant in the cycle before");

endmodule

//--- verif/eth_stat_quad_tb.sv
// Testbench for the quad statistics block with a reference model of the interval counters
`timescale 1ns/1ps

module eth_stat_quad_tb;

    import stat_pkg::*;

    localparam int CNT = DEFAULT_CNT;
    localparam int PERIOD = DEFAULT_UPDATE_PERIOD;
    localparam int ID_BASE = DEFAULT_ID_BASE;
    localparam int NREC = CNT * STATS_PER_CH;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_INTERVALS = 8;
    // Last burst ends NREC + 1 edges after the last tick
    localparam int END_EDGE = NUM_INTERVALS * PERIOD + NREC + 4;
    localparam int WATCHDOG_CYCLES = END_EDGE + 3 + 200;

    logic      stat_clk = 1'b0;
    logic      rst_n;
    ch_stat_t  stat_in [CNT] = '{default: '0};
    logic      m_stat_valid;
    stat_rec_t m_stat_rec;

    // Reference model state
    stat_val_t model_acc [CNT][STATS_PER_CH] = '{default: '0};
    stat_rec_t exp_q [$];
    int        edge_cnt = 0;
    int        last_tick = 0;
    logic      run_done = 1'b0;

    eth_stat_quad #(
        .CNT(CNT),
        .STAT_UPDATE_PERIOD(PERIOD),
        .STAT_ID_BASE(ID_BASE)
    ) i_eth_stat_quad (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .stat_in(stat_in),
        .m_stat_valid(m_stat_valid),
        .m_stat_rec(m_stat_rec)
    );

    bind stat_arb_mux eth_stat_quad_chk #(
        .CNT(CNT)
    ) i_eth_stat_quad_chk (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .req(req),
        .grant(grant),
        .m_stat_valid(m_stat_valid)
    );

    always #(CLK_PERIOD / 2) stat_clk = ~stat_clk;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected 0x%0h got 0x%0h",
                     $time, what, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Index 0 to 3 in field order
    function automatic stat_inc_t field_inc(ch_stat_t s, int idx);
        case (idx)
            0: return s.tx_byte;
            1: return s.tx_pkt;
            2: return s.rx_byte;
            default: return s.rx_pkt;
        endcase
    endfunction

    // Traffic profile per interval, some channels idle for whole intervals
    function automatic stat_inc_t random_inc(int interval, int ch);
        case (interval)
            0: return stat_inc_t'($urandom_range(15, 0));
            1: return (ch % 2 == 1) ? '0 : stat_inc_t'($urandom_range(3, 0));
            2: return (ch == 0) ? '0 : stat_inc_t'($urandom_range(15, 12));
            3: return '0;
            4: return (ch == 2) ? '0 : stat_inc_t'($urandom_range(15, 0));
            default: return stat_inc_t'($urandom_range(15, 12));
        endcase
    endfunction

    function automatic ch_stat_t random_stat(int interval, int ch);
        ch_stat_t s;

        s.tx_byte = random_inc(interval, ch);
        s.tx_pkt  = random_inc(interval, ch);
        s.rx_byte = random_inc(interval, ch);
        s.rx_pkt  = random_inc(interval, ch);
        return s;
    endfunction

    // Model, output check and stimulus, all on the rising edge
    always @(posedge stat_clk) begin : model
        stat_rec_t exp_rec;
        bit        exp_valid;

        if (rst_n) begin
            edge_cnt = edge_cnt + 1;

            exp_valid = (last_tick > 0) && (edge_cnt >= last_tick + 2) &&
                        (edge_cnt <= last_tick + 1 + NREC);
            check_equal(32'(m_stat_valid), 32'(exp_valid), "m_stat_valid");
            if (exp_valid) begin
                exp_rec = exp_q.pop_front();
                check_equal(32'(m_stat_rec.id), 32'(exp_rec.id), "record id");
                check_equal(32'(m_stat_rec.value), 32'(exp_rec.value), "record value");
            end

            if (edge_cnt % PERIOD == 0) begin
                last_tick = edge_cnt;
                // Channel-interleaved: all idx0 records, then idx1 and so on
                for (int idx = 0; idx < STATS_PER_CH; idx++) begin
                    for (int ch = 0; ch < CNT; ch++) begin
                        exp_rec.id = stat_id_t'(ID_BASE + ch * STATS_PER_CH + idx);
                        exp_rec.value = model_acc[ch][idx];
                        exp_q.push_back(exp_rec);
                    end
                end
                // Increment seen on the tick belongs to the next interval
                for (int ch = 0; ch < CNT; ch++) begin
                    for (int idx = 0; idx < STATS_PER_CH; idx++) begin
                        model_acc[ch][idx] = stat_val_t'(field_inc(stat_in[ch], idx));
                    end
                end
            end else begin
                for (int ch = 0; ch < CNT; ch++) begin
                    for (int idx = 0; idx < STATS_PER_CH; idx++) begin
                        model_acc[ch][idx] = model_acc[ch][idx] +
                                             stat_val_t'(field_inc(stat_in[ch], idx));
                    end
                end
            end

            if (edge_cnt == END_EDGE) begin
                run_done = 1'b1;
            end

            // Value driven now is sampled at the next edge
            for (int ch = 0; ch < CNT; ch++) begin
                stat_in[ch] <= random_stat((edge_cnt + 1) / PERIOD, ch);
            end
        end else begin
            for (int ch = 0; ch < CNT; ch++) begin
                stat_in[ch] <= '0;
            end
        end
    end

    initial begin : main
        void'($urandom(85));
        rst_n <= 1'b0;
        repeat (3) @(posedge stat_clk);
        rst_n <= 1'b1;

        wait (run_done);
        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

//--- eth_stat_quad.f
logic/stat_pkg.sv
logic/stat_period_timer.sv
logic/stat_collector.sv
logic/stat_arb_mux.sv
logic/eth_stat_quad.sv
verif/eth_stat_quad_chk.sv
verif/eth_stat_quad_tb.sv

//--- Makefile
# Verilator build and run for the quad statistics block

VERILATOR ?= verilator
TOP       ?= eth_stat_quad_tb
FLIST     ?= eth_stat_quad.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
PASS_MSG  ?= Testbench passed

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	status=$$?; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	    exit 0; \
	else \
	    echo "simulation exit status $$status"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
